// ==== dv/rv_tb.sv ====
// testbench for rv_top, runs the program held in tb_imem and checks every retirement
`timescale 1ns/1ps

module rv_tb import rv_pkg::*; ();

    localparam xlen_t RESET_PC     = '0;
    localparam int    DMEM_WORDS   = 256;
    localparam int    TRACE_LEN    = 25;
    localparam int    HALT_TIMEOUT = 200;
    localparam int    QUIET_CYCLES = 20;

    logic        clk = 1'b0;
    logic        reset_i;
    xlen_t       imem_addr;
    logic [31:0] imem_data;
    logic        retire_valid;
    xlen_t       retire_pc;
    logic        retire_wen;
    logic [4:0]  retire_waddr;
    xlen_t       retire_wdata;
    logic        halted;

    int          value_errs = 0;
    int          other_errs = 0;
    int          ret_idx = 0;      // next trace entry to retire
    logic        reset_q = 1'b0;
    logic        in_trace;
    xlen_t       cur_pc;
    logic [4:0]  cur_waddr;
    xlen_t       cur_wdata;
    logic        cur_wen;

    // expected retire trace, waddr 0 marks an instruction without a register write
    xlen_t exp_pc [TRACE_LEN] = '{
        'h00, 'h04, 'h08, 'h0c, 'h10, 'h14, 'h18, 'h1c, 'h20, 'h24, 'h28, 'h2c, 'h30,
        'h34, 'h38, 'h3c, 'h40, 'h44, 'h48, 'h50, 'h54, 'h58, 'h64, 'h70, 'h74};
    logic [4:0] exp_waddr [TRACE_LEN] = '{
        1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 15, 0, 16, 17, 0, 0, 0, 0, 20, 21, 0};
    xlen_t exp_wdata [TRACE_LEN] = '{
        5, 8, 13, 8, 8, 13, 5, 1, 26, 13, 'h1234_5000, 'h1234_500d, 64'hffff_ffff_ffff_ffff,
        1, 64'hffff_ffff_8000_0000, 0, 'h1234_500d, 'h1234_5012, 0, 0, 0, 0, 'h68, 'h69, 0};

    always #2 clk = ~clk;

    rv_top #(.RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS)) DUT (
        .clk            (clk),
        .reset_i        (reset_i),
        .imem_addr_o    (imem_addr),
        .imem_data_i    (imem_data),
        .retire_valid_o (retire_valid),
        .retire_pc_o    (retire_pc),
        .retire_wen_o   (retire_wen),
        .retire_waddr_o (retire_waddr),
        .retire_wdata_o (retire_wdata),
        .halted_o       (halted)
    );

    tb_imem u_imem (
        .addr_i (imem_addr),
        .data_o (imem_data)
    );

    always @(posedge clk) begin
        reset_q <= reset_i;
        if (!reset_i && retire_valid) begin
            ret_idx <= ret_idx + 1;
        end
    end

    assign in_trace = (ret_idx < TRACE_LEN);
    assign cur_wen  = (cur_waddr != 5'd0);

    always_comb begin
        cur_pc    = '0;
        cur_waddr = '0;
        cur_wdata = '0;
        if (in_trace) begin
            cur_pc    = exp_pc[ret_idx];
            cur_waddr = exp_waddr[ret_idx];
            cur_wdata = exp_wdata[ret_idx];
        end
    end

    a_reset_pc: assert property (@(posedge clk) reset_q |-> imem_addr == RESET_PC)
        else begin
            value_errs++;
            $display("ERR %0t imem_addr_o expected %h got %h", $time, RESET_PC,
                     $sampled(imem_addr));
        end

    a_reset_idle: assert property (@(posedge clk) reset_q |-> !retire_valid && !halted)
        else begin
            other_errs++;
            $display("retire or halt active during or right after reset at %0t", $time);
        end

    a_trace_end: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid |-> in_trace)
        else begin
            other_errs++;
            $display("more retirements than the expected trace holds at %0t", $time);
        end

    a_retire_pc: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid && in_trace |-> retire_pc == cur_pc)
        else begin
            value_errs++;
            $display("ERR %0t retire_pc_o expected %h got %h", $time,
                     $sampled(cur_pc), $sampled(retire_pc));
        end

    a_retire_wen: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid && in_trace |-> retire_wen == cur_wen)
        else begin
            value_errs++;
            $display("ERR %0t retire_wen_o expected %b got %b", $time,
                     $sampled(cur_wen), $sampled(retire_wen));
        end

    a_retire_waddr: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid && in_trace && cur_wen |-> retire_waddr == cur_waddr)
        else begin
            value_errs++;
            $display("ERR %0t retire_waddr_o expected %0d got %0d", $time,
                     $sampled(cur_waddr), $sampled(retire_waddr));
        end

    a_retire_wdata: assert property (@(posedge clk) disable iff (reset_i)
        retire_valid && in_trace && cur_wen |-> retire_wdata == cur_wdata)
        else begin
            value_errs++;
            $display("ERR %0t retire_wdata_o expected %h got %h", $time,
                     $sampled(cur_wdata), $sampled(retire_wdata));
        end

    // halt comes up together with the ebreak, the last trace entry
    a_halt_rise: assert property (@(posedge clk) disable iff (reset_i)
        $rose(halted) |-> retire_valid && ret_idx == TRACE_LEN - 1)
        else begin
            other_errs++;
            $display("halt rose without the ebreak retiring at %0t", $time);
        end

    a_halt_sticky: assert property (@(posedge clk) disable iff (reset_i)
        halted |=> halted)
        else begin
            other_errs++;
            $display("halted_o dropped after it was set at %0t", $time);
        end

    a_no_retire_after_halt: assert property (@(posedge clk) disable iff (reset_i)
        halted |=> !retire_valid)
        else begin
            other_errs++;
            $display("an instruction retired after the halt at %0t", $time);
        end

    task automatic wait_for_halt(output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < HALT_TIMEOUT) begin
            @(posedge clk);
            #1;
            seen = halted;
            n++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        logic halted_seen;
        reset_i = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset_i = 1'b0;
        wait_for_halt(halted_seen);
        if (!halted_seen) begin
            other_errs++;
            $display("program did not halt in time, gave up after %0d cycles", HALT_TIMEOUT);
        end else begin
            repeat (QUIET_CYCLES) @(posedge clk);    // assertions watch for late retirements
            #1;
            a_retire_count: assert (ret_idx == TRACE_LEN)
                else begin
                    value_errs++;
                    $display("ERR %0t retire count expected %0d got %0d", $time,
                             TRACE_LEN, ret_idx);
                end
        end
        finish_run();
    end

endmodule

// ==== dv/tb_imem.sv ====
// instruction ROM model for the testbench, holds the test program and answers fetches at once
`timescale 1ns/1ps

module tb_imem import rv_pkg::*; (
    input  xlen_t       addr_i,
    output logic [31:0] data_o
);

    localparam logic [31:0] NOP    = 32'h0000_0013;    // addi x0, x0, 0
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    function automatic logic [31:0] addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_rr(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] lui(logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] ld(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b011, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sd(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    always_comb begin
        data_o = NOP;
        if (addr_i[XLEN-1:8] == '0) begin
            case (addr_i[7:0])
                8'h00: data_o = addi(5'd1, 5'd0, 12'd5);
                8'h04: data_o = addi(5'd2, 5'd1, 12'd3);                // x1 from execute
                8'h08: data_o = alu_rr(7'h00, 3'b000, 5'd3, 5'd2, 5'd1);   // add
                8'h0c: data_o = alu_rr(7'h20, 3'b000, 5'd4, 5'd3, 5'd1);   // sub, x1 from wb
                8'h10: data_o = alu_rr(7'h00, 3'b111, 5'd5, 5'd4, 5'd3);   // and
                8'h14: data_o = alu_rr(7'h00, 3'b110, 5'd6, 5'd5, 5'd1);   // or
                8'h18: data_o = alu_rr(7'h00, 3'b100, 5'd7, 5'd6, 5'd2);   // xor
                8'h1c: data_o = alu_rr(7'h00, 3'b010, 5'd8, 5'd7, 5'd6);   // slt
                8'h20: data_o = alu_rr(7'h00, 3'b001, 5'd9, 5'd6, 5'd8);   // sll
                8'h24: data_o = alu_rr(7'h00, 3'b101, 5'd10, 5'd9, 5'd8);  // srl
                8'h28: data_o = lui(5'd11, 20'h12345);
                8'h2c: data_o = alu_rr(7'h00, 3'b000, 5'd12, 5'd11, 5'd10);
                8'h30: data_o = addi(5'd13, 5'd0, 12'hfff);             // minus one
                8'h34: data_o = alu_rr(7'h00, 3'b010, 5'd14, 5'd13, 5'd1); // signed slt
                8'h38: data_o = lui(5'd15, 20'h80000);                  // sign extends
                8'h3c: data_o = sd(5'd12, 5'd0, 12'd16);
                8'h40: data_o = ld(5'd16, 5'd0, 12'd16);
                8'h44: data_o = alu_rr(7'h00, 3'b000, 5'd17, 5'd16, 5'd1); // load-use
                8'h48: data_o = branch(3'b000, 5'd1, 5'd7, 13'd8);      // beq taken
                8'h4c: data_o = addi(5'd18, 5'd0, 12'd99);              // wrong path
                8'h50: data_o = branch(3'b001, 5'd1, 5'd7, 13'd8);      // bne not taken
                8'h54: data_o = branch(3'b000, 5'd1, 5'd2, 13'd8);      // beq not taken
                8'h58: data_o = branch(3'b001, 5'd1, 5'd2, 13'd12);     // bne taken
                8'h5c: data_o = addi(5'd18, 5'd0, 12'd77);
                8'h60: data_o = addi(5'd19, 5'd0, 12'd66);
                8'h64: data_o = jal(5'd20, 21'd12);
                8'h68: data_o = addi(5'd18, 5'd0, 12'd55);
                8'h6c: data_o = addi(5'd19, 5'd0, 12'd44);
                8'h70: data_o = addi(5'd21, 5'd20, 12'd1);              // uses link value
                8'h74: data_o = EBREAK;
                default: data_o = NOP;
            endcase
        end
    end

endmodule

// ==== sim.f ====
verilog/rv_pkg.sv
verilog/bypass_if.sv
verilog/stage_reg.sv
verilog/if_stage.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/rv_top.sv
dv/tb_imem.sv
dv/rv_tb.sv

// ==== verilog/bypass_if.sv ====
// result bus from execute and memory back to decode, used for forwarding and load-use stalls
`timescale 1ns/1ps

interface bypass_if import rv_pkg::*; ();

    logic       ex_wen;
    logic [4:0] ex_waddr;
    xlen_t      ex_result;
    logic       ex_is_load;    // result is only an address
    logic       mem_wen;
    logic [4:0] mem_waddr;
    xlen_t      mem_wdata;     // load data or alu result

    modport ex_side  (output ex_wen, ex_waddr, ex_result, ex_is_load);
    modport mem_side (output mem_wen, mem_waddr, mem_wdata);
    modport id_side  (input  ex_wen, ex_waddr, ex_result, ex_is_load,
                             mem_wen, mem_waddr, mem_wdata);

endinterface

// ==== verilog/ex_stage.sv ====
// execute stage, ALU, branch compare and redirect to fetch
`timescale 1ns/1ps

module ex_stage import rv_pkg::*; (
    input  id_ex_t     id_ex_i,
    bypass_if.ex_side  byp,
    output ex_mem_t    ex_mem_o,
    output logic       redirect_valid_o,
    output xlen_t      redirect_pc_o
);

    xlen_t alu_res;
    logic  taken;
    logic  src_eq;

    always_comb begin
        case (id_ex_i.alu_op)
            op_add:    alu_res = id_ex_i.src1 + id_ex_i.src2;
            op_sub:    alu_res = id_ex_i.src1 - id_ex_i.src2;
            op_and:    alu_res = id_ex_i.src1 & id_ex_i.src2;
            op_or:     alu_res = id_ex_i.src1 | id_ex_i.src2;
            op_xor:    alu_res = id_ex_i.src1 ^ id_ex_i.src2;
            op_slt:    alu_res = {{(XLEN-1){1'b0}},
                                  $signed(id_ex_i.src1) < $signed(id_ex_i.src2)};
            op_sll:    alu_res = id_ex_i.src1 << id_ex_i.src2[5:0];
            op_srl:    alu_res = id_ex_i.src1 >> id_ex_i.src2[5:0];
            op_pass_b: alu_res = id_ex_i.src2;
            default:   alu_res = id_ex_i.src1 + id_ex_i.src2;
        endcase
    end

    assign src_eq = (id_ex_i.src1 == id_ex_i.src2);

    always_comb begin
        case (id_ex_i.br_kind)
            br_beq:  taken = src_eq;
            br_bne:  taken = !src_eq;
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_valid_o = id_ex_i.valid && taken;   // one cycle, flushes two slots
    assign redirect_pc_o    = id_ex_i.br_target;

    assign ex_mem_o = '{valid:      id_ex_i.valid,
                        pc:         id_ex_i.pc,
                        result:     alu_res,
                        store_data: id_ex_i.store_data,
                        reg_wen:    id_ex_i.reg_wen,
                        waddr:      id_ex_i.waddr,
                        mem_rd:     id_ex_i.mem_rd,
                        mem_wr:     id_ex_i.mem_wr,
                        ebreak:     id_ex_i.ebreak};

    assign byp.ex_wen     = id_ex_i.valid && id_ex_i.reg_wen;
    assign byp.ex_waddr   = id_ex_i.waddr;
    assign byp.ex_result  = alu_res;
    assign byp.ex_is_load = id_ex_i.valid && id_ex_i.mem_rd;

    always_comb begin
        if (redirect_valid_o) begin
            assert final (redirect_pc_o[1:0] == 2'b00)
                else $error("redirect target %h not word aligned", redirect_pc_o);
        end
    end

endmodule

// ==== verilog/id_stage.sv ====
// decode stage with register file, operand forwarding, load-use stall and halt fetch stop
`timescale 1ns/1ps

module id_stage import rv_pkg::*; (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        id_valid_i,
    input  xlen_t       id_pc_i,
    input  logic [31:0] id_inst_i,
    input  logic        redirect_valid_i,
    bypass_if.id_side   byp,
    input  mem_wb_t     wb_i,
    output id_ex_t      id_ex_o,
    output logic        stall_o,
    output logic        fetch_stop_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_j;
    xlen_t      imm_u;
    logic       uses_rs1;
    logic       uses_rs2;
    logic [4:0] rs_addr [2];
    xlen_t      rs_val [2];
    xlen_t      regs [32];
    logic       stop_q;
    id_ex_t     dec;

    assign opcode = id_inst_i[6:0];
    assign funct3 = id_inst_i[14:12];
    assign rd     = id_inst_i[11:7];
    assign rs1    = id_inst_i[19:15];
    assign rs2    = id_inst_i[24:20];

    assign imm_i = {{52{id_inst_i[31]}}, id_inst_i[31:20]};
    assign imm_s = {{52{id_inst_i[31]}}, id_inst_i[31:25], id_inst_i[11:7]};
    assign imm_b = {{52{id_inst_i[31]}}, id_inst_i[7], id_inst_i[30:25],
                    id_inst_i[11:8], 1'b0};
    assign imm_j = {{44{id_inst_i[31]}}, id_inst_i[19:12], id_inst_i[20],
                    id_inst_i[30:21], 1'b0};
    assign imm_u = {{32{id_inst_i[31]}}, id_inst_i[31:12], 12'h000};

    // writeback port, the same write is forwarded below
    always_ff @(posedge clk) begin
        if (wb_i.valid && wb_i.reg_wen && wb_i.waddr != 5'd0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rs_addr[0] = rs1;
    assign rs_addr[1] = rs2;

    always_comb begin
        for (int k = 0; k < 2; k++) begin
            if (rs_addr[k] == 5'd0) begin
                rs_val[k] = '0;
            end else if (byp.ex_wen && byp.ex_waddr == rs_addr[k]) begin
                rs_val[k] = byp.ex_result;     // youngest first
            end else if (byp.mem_wen && byp.mem_waddr == rs_addr[k]) begin
                rs_val[k] = byp.mem_wdata;
            end else if (wb_i.valid && wb_i.reg_wen && wb_i.waddr == rs_addr[k]) begin
                rs_val[k] = wb_i.wdata;
            end else begin
                rs_val[k] = regs[rs_addr[k]];
            end
        end
    end

    always_comb begin
        dec            = '0;
        dec.valid      = 1'b1;
        dec.pc         = id_pc_i;
        dec.alu_op     = op_add;
        dec.src1       = rs_val[0];
        dec.src2       = rs_val[1];
        dec.store_data = rs_val[1];
        dec.br_kind    = br_none;
        dec.br_target  = id_pc_i + imm_b;
        uses_rs1       = 1'b0;
        uses_rs2       = 1'b0;
        case (opcode)
            7'b0010011: begin                  // addi
                dec.src2    = imm_i;
                dec.reg_wen = 1'b1;
                uses_rs1    = 1'b1;
            end
            7'b0110011: begin
                dec.reg_wen = 1'b1;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = id_inst_i[30] ? op_sub : op_add;
                    3'b001:  dec.alu_op = op_sll;
                    3'b010:  dec.alu_op = op_slt;
                    3'b100:  dec.alu_op = op_xor;
                    3'b101:  dec.alu_op = op_srl;
                    3'b110:  dec.alu_op = op_or;
                    default: dec.alu_op = op_and;
                endcase
            end
            7'b0110111: begin                  // lui
                dec.alu_op  = op_pass_b;
                dec.src2    = imm_u;
                dec.reg_wen = 1'b1;
            end
            7'b0000011: begin                  // ld
                dec.src2    = imm_i;
                dec.reg_wen = 1'b1;
                dec.mem_rd  = 1'b1;
                uses_rs1    = 1'b1;
            end
            7'b0100011: begin                  // sd
                dec.src2   = imm_s;
                dec.mem_wr = 1'b1;
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
            end
            7'b1100011: begin
                dec.br_kind = funct3[0] ? br_bne : br_beq;
                uses_rs1    = 1'b1;
                uses_rs2    = 1'b1;
            end
            7'b1101111: begin                  // jal, link is pc + 4
                dec.src1      = id_pc_i;
                dec.src2      = xlen_t'(4);
                dec.reg_wen   = 1'b1;
                dec.br_kind   = br_jal;
                dec.br_target = id_pc_i + imm_j;
            end
            7'b1110011: dec.ebreak = id_inst_i[20];
            default: ;
        endcase
        dec.reg_wen = dec.reg_wen && (rd != 5'd0);
        dec.waddr   = rd;
    end

    // load result not ready until memory, hold decode one cycle
    assign stall_o = id_valid_i && byp.ex_is_load && byp.ex_waddr != 5'd0 &&
                     ((uses_rs1 && byp.ex_waddr == rs1) ||
                      (uses_rs2 && byp.ex_waddr == rs2));

    assign id_ex_o = (!id_valid_i || stall_o || stop_q) ? '0 : dec;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stop_q <= 1'b0;
        end else if (id_valid_i && dec.ebreak && !redirect_valid_i && !stall_o) begin
            stop_q <= 1'b1;                    // sticky until reset
        end
    end

    assign fetch_stop_o = stop_q;

    // the bubble reaches execute next cycle, so the stall cannot repeat
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |=> !stall_o)
        else $error("load-use stall lasted more than one cycle");

endmodule

// ==== verilog/if_stage.sv ====
// fetch stage, owns the program counter and the fetch/decode register
`timescale 1ns/1ps

module if_stage import rv_pkg::*; #(
    parameter xlen_t RESET_PC = '0
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        stall_i,
    input  logic        fetch_stop_i,
    input  logic        redirect_valid_i,
    input  xlen_t       redirect_pc_i,
    output xlen_t       imem_addr_o,
    input  logic [31:0] imem_data_i,
    output logic        id_valid_o,
    output xlen_t       id_pc_o,
    output logic [31:0] id_inst_o
);

    xlen_t pc_q;

    assign imem_addr_o = pc_q;    // instruction memory reads combinationally

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_valid_i) begin
            pc_q <= redirect_pc_i;    // wins over stall
        end else if (!stall_i && !fetch_stop_i) begin
            pc_q <= pc_q + xlen_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || redirect_valid_i) begin
            id_valid_o <= 1'b0;       // kills the wrong-path slot
        end else if (!stall_i) begin
            id_valid_o <= !fetch_stop_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= imem_data_i;
        end
    end

    // redirect targets come from execute, so this also checks the branch adder
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
        pc_q[1:0] == 2'b00)
        else $error("fetch pc %h not word aligned", pc_q);

endmodule

// ==== verilog/mem_stage.sv ====
// memory stage, doubleword data RAM, writeback data select and sticky halt flag
`timescale 1ns/1ps

module mem_stage import rv_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic       clk,
    input  logic       reset_i,
    input  ex_mem_t    ex_mem_i,
    bypass_if.mem_side byp,
    output mem_wb_t    mem_wb_o,
    output logic       halted_o
);

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    xlen_t            ram [DMEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    xlen_t            load_data;
    xlen_t            wdata;
    logic             halt_q;

    // doubleword index, address wraps inside the RAM
    assign word_idx = IDX_W'((ex_mem_i.result >> 3) % DMEM_WORDS);

    always_ff @(posedge clk) begin
        if (ex_mem_i.valid && ex_mem_i.mem_wr) begin
            ram[word_idx] <= ex_mem_i.store_data;
        end
    end

    assign load_data = ram[word_idx];    // combinational read
    assign wdata     = ex_mem_i.mem_rd ? load_data : ex_mem_i.result;

    assign mem_wb_o = '{valid:   ex_mem_i.valid,
                        pc:      ex_mem_i.pc,
                        reg_wen: ex_mem_i.reg_wen,
                        waddr:   ex_mem_i.waddr,
                        wdata:   wdata,
                        ebreak:  ex_mem_i.ebreak};

    assign byp.mem_wen   = ex_mem_i.valid && ex_mem_i.reg_wen;
    assign byp.mem_waddr = ex_mem_i.waddr;
    assign byp.mem_wdata = wdata;

    // rises together with the ebreak reaching retire
    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q <= 1'b0;
        end else if (ex_mem_i.valid && ex_mem_i.ebreak) begin
            halt_q <= 1'b1;
        end
    end

    assign halted_o = halt_q;

    a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset_i)
        !(ex_mem_i.mem_rd && ex_mem_i.mem_wr))
        else $error("load and store flagged on one instruction");

endmodule

// ==== verilog/rv_pkg.sv ====
// shared widths, ALU and branch encodings, and pipeline payload structs for the RV64I core
package rv_pkg;

    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] xlen_t;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,     // signed compare
        op_sll,
        op_srl,
        op_pass_b   // lui, passes the immediate
    } alu_op_e;

    typedef enum logic [1:0] {
        br_none,
        br_beq,
        br_bne,
        br_jal
    } br_kind_e;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        alu_op_e    alu_op;
        xlen_t      src1;
        xlen_t      src2;
        xlen_t      store_data;
        br_kind_e   br_kind;
        xlen_t      br_target;
        logic       reg_wen;    // already cleared for rd == x0
        logic [4:0] waddr;
        logic       mem_rd;
        logic       mem_wr;
        logic       ebreak;
    } id_ex_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        xlen_t      result;     // alu result or memory address
        xlen_t      store_data;
        logic       reg_wen;
        logic [4:0] waddr;
        logic       mem_rd;
        logic       mem_wr;
        logic       ebreak;
    } ex_mem_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        logic       reg_wen;
        logic [4:0] waddr;
        xlen_t      wdata;
        logic       ebreak;
    } mem_wb_t;

endpackage

// ==== verilog/rv_top.sv ====
// five-stage RV64I pipeline top, instruction memory port and retire trace outputs
`timescale 1ns/1ps

module rv_top import rv_pkg::*; #(
    parameter xlen_t RESET_PC   = '0,
    parameter int    DMEM_WORDS = 256
) (
    input  logic        clk,
    input  logic        reset_i,
    output xlen_t       imem_addr_o,
    input  logic [31:0] imem_data_i,
    output logic        retire_valid_o,
    output xlen_t       retire_pc_o,
    output logic        retire_wen_o,
    output logic [4:0]  retire_waddr_o,
    output xlen_t       retire_wdata_o,
    output logic        halted_o
);

    logic        id_valid;
    xlen_t       id_pc;
    logic [31:0] id_inst;
    logic        stall;
    logic        fetch_stop;
    logic        redirect_valid;
    xlen_t       redirect_pc;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;
    ex_mem_t     ex_mem_d;
    ex_mem_t     ex_mem_q;
    mem_wb_t     mem_wb_d;
    mem_wb_t     mem_wb_q;

    bypass_if u_byp ();

    if_stage #(.RESET_PC(RESET_PC)) u_if_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall),
        .fetch_stop_i     (fetch_stop),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .imem_addr_o      (imem_addr_o),
        .imem_data_i      (imem_data_i),
        .id_valid_o       (id_valid),
        .id_pc_o          (id_pc),
        .id_inst_o        (id_inst)
    );

    id_stage u_id_stage (
        .clk              (clk),
        .reset_i          (reset_i),
        .id_valid_i       (id_valid),
        .id_pc_i          (id_pc),
        .id_inst_i        (id_inst),
        .redirect_valid_i (redirect_valid),
        .byp              (u_byp.id_side),
        .wb_i             (mem_wb_q),         // register file write port
        .id_ex_o          (id_ex_d),
        .stall_o          (stall),
        .fetch_stop_o     (fetch_stop)
    );

    stage_reg #(.T_PAYLOAD(id_ex_t)) u_id_ex (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (redirect_valid),   // drops the wrong-path decode
        .stall_i (1'b0),
        .d_i     (id_ex_d),
        .q_o     (id_ex_q)
    );

    ex_stage u_ex_stage (
        .id_ex_i          (id_ex_q),
        .byp              (u_byp.ex_side),
        .ex_mem_o         (ex_mem_d),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    stage_reg #(.T_PAYLOAD(ex_mem_t)) u_ex_mem (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (1'b0),
        .stall_i (1'b0),
        .d_i     (ex_mem_d),
        .q_o     (ex_mem_q)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem_stage (
        .clk      (clk),
        .reset_i  (reset_i),
        .ex_mem_i (ex_mem_q),
        .byp      (u_byp.mem_side),
        .mem_wb_o (mem_wb_d),
        .halted_o (halted_o)
    );

    stage_reg #(.T_PAYLOAD(mem_wb_t)) u_mem_wb (
        .clk     (clk),
        .reset_i (reset_i),
        .flush_i (1'b0),
        .stall_i (1'b0),
        .d_i     (mem_wb_d),
        .q_o     (mem_wb_q)
    );

    assign retire_valid_o = mem_wb_q.valid;
    assign retire_pc_o    = mem_wb_q.pc;
    assign retire_wen_o   = mem_wb_q.valid && mem_wb_q.reg_wen;
    assign retire_waddr_o = mem_wb_q.waddr;
    assign retire_wdata_o = mem_wb_q.wdata;

endmodule

// ==== verilog/stage_reg.sv ====
// generic pipeline register between stages, instantiated once per payload struct
`timescale 1ns/1ps

module stage_reg #(
    parameter type T_PAYLOAD = logic
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     flush_i,
    input  logic     stall_i,
    input  T_PAYLOAD d_i,
    output T_PAYLOAD q_o
);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_o <= '0;            // zero payload is a bubble
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule
